/* fdc_bus_regs.sv */
// floppy controller cpu register stage
// holds command, sector and data registers, builds the status byte
// and sends command and track strobes to the execute stage
// also serves the register view of the io controller

module fdc_bus_regs (
  input  logic                 clk,
  input  logic                 motor_start,
  // cpu bus
  input  logic                 cpu_sel,
  input  logic                 cpu_rw,       // high = read
  input  fdc_pkg::reg_addr_t   cpu_addr,
  input  fdc_pkg::reg_byte_t   cpu_din,
  output fdc_pkg::reg_byte_t   cpu_dout,
  // io controller view
  input  fdc_pkg::status_sel_t status_sel,
  output fdc_pkg::reg_byte_t   status_byte,
  // drive pins
  input  logic [1:0]           drv_sel,
  input  logic                 drv_side,
  input  logic                 wr_prot,
  // back from execute stage and drive timer
  input  fdc_pkg::reg_byte_t   track,
  input  logic                 busy,
  input  logic                 io_wait,
  input  logic                 motor_on,
  input  logic                 spin_up_done,
  input  logic                 index_pulse,
  // toward execute stage
  output logic                 cmd_valid,
  output fdc_pkg::reg_byte_t   cmd_byte,
  output fdc_pkg::reg_byte_t   wr_byte,
  output logic                 track_wr,
  output fdc_pkg::reg_byte_t   data_byte,
  output logic                 irq_ack
);
  import fdc_pkg::*;

  reg_byte_t cmd_reg;     // write only from the cpu side
  reg_byte_t sector_reg;
  reg_byte_t data_reg;
  reg_byte_t status;      // what a read of address 0 returns
  logic      cpu_wr;
  logic      cmd_type_1;

  assign cpu_wr     = cpu_sel && !cpu_rw;
  assign cmd_type_1 = ~cmd_reg[7];  // restore/seek/step family

  // register writes and strobes
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start) begin
      cmd_reg    <= '0;
      sector_reg <= '0;
      data_reg   <= '0;
      wr_byte    <= '0;
      cmd_valid  <= 1'b0;
      track_wr   <= 1'b0;
      irq_ack    <= 1'b0;
    end else begin
      cmd_valid <= cpu_wr && (cpu_addr == 2'd0);  // one pulse per write
      track_wr  <= cpu_wr && (cpu_addr == 2'd1);
      irq_ack   <= cpu_sel && (cpu_addr == 2'd0); // read or write of reg 0
      if (cpu_wr) begin
        case (cpu_addr)
          2'd0: cmd_reg    <= cpu_din;
          2'd1: wr_byte    <= cpu_din;  // track itself lives in the execute stage
          2'd2: sector_reg <= cpu_din;
          2'd3: data_reg   <= cpu_din;
        endcase
      end
    end
  end

  assign cmd_byte  = cmd_reg;
  assign data_byte = data_reg;  // seek target always visible

  // status byte from bit 7 down to bit 0
  assign status = {
    motor_on,
    wr_prot,
    cmd_type_1 ? spin_up_done : 1'b0,
    2'b00,                             // no record-not-found or crc
    cmd_type_1 ? (track == 8'h00) : 1'b0,
    cmd_type_1 ? index_pulse : busy,   // index or drq-like busy copy
    busy
  };

  // cpu read mux
  always_comb begin
    cpu_dout = '0;
    if (cpu_sel && cpu_rw) begin
      case (cpu_addr)
        2'd0: cpu_dout = status;
        2'd1: cpu_dout = track;
        2'd2: cpu_dout = sector_reg;
        2'd3: cpu_dout = data_reg;
      endcase
    end
  end

  // io controller register view
  always_comb begin
    case (status_sel)
      3'd0:    status_byte = cmd_reg;
      3'd1:    status_byte = track;
      3'd2:    status_byte = sector_reg;
      3'd3:    status_byte = data_reg;
      3'd4:    status_byte = {4'b0000, drv_sel, drv_side, io_wait};
      default: status_byte = '0;
    endcase
  end

  // a cpu access hits one address per cycle
  a_strobe_excl: assert property (@(posedge clk) disable iff (motor_start)
    !(cmd_valid && track_wr));

endmodule

/* fdc_cmd_exec.sv */
// floppy controller command execution stage
// decodes type I to IV commands, runs the busy state machine,
// owns track register, step direction, delay counter and irq
`include "fdc_settings.svh"

module fdc_cmd_exec (
  input  logic               clk,
  input  logic               motor_start,
  // from bus stage
  input  logic               cmd_valid,
  input  fdc_pkg::reg_byte_t cmd_byte,
  input  fdc_pkg::reg_byte_t wr_byte,
  input  logic               track_wr,
  input  fdc_pkg::reg_byte_t data_byte,
  input  logic               irq_ack,
  // drive and io controller
  input  logic               wr_prot,
  input  logic               io_ready,
  // results
  output fdc_pkg::reg_byte_t track,
  output logic               busy,
  output logic               io_wait,
  output logic               irq,
  output logic               spin_trigger
);
  import fdc_pkg::*;

  localparam fdc_count_t RESTORE_DLY = fdc_count_t'(`FDC_RESTORE_DELAY);
  localparam fdc_count_t STEP_DLY    = fdc_count_t'(`FDC_STEP_DELAY);

  busy_state_t state;
  fdc_count_t  delay;      // remaining internal wait
  logic        step_dir;   // 1 = toward higher tracks
  logic        is_type_1;
  logic        is_type_2;

  // class of the incoming command
  assign is_type_1 = ~cmd_byte[7];
  assign is_type_2 = (cmd_byte[7:6] == 2'b10);

  assign busy    = (state != st_idle);
  assign io_wait = (state == st_io_wait);

  // busy state machine, track and step direction
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start) begin
      state    <= st_idle;
      delay    <= '0;
      track    <= '0;
      step_dir <= 1'b0;
    end else begin
      // normal progression
      case (state)
        st_int_wait: begin
          if (delay != '0)
            delay <= delay - 1'b1;
          else
            state <= st_irq;  // wait done
        end
        st_irq:     state <= st_idle;
        st_io_wait: if (io_ready) state <= st_irq;  // transfer done
        default:    ;
      endcase

      if (track_wr)
        track <= wr_byte;  // cpu loads track directly

      // a command is always taken, even while busy
      if (cmd_valid) begin
        state <= st_int_wait;  // default zero length wait
        delay <= '0;
        casez (cmd_byte[7:4])
          4'b0000: begin        // restore
            track <= '0;
            delay <= RESTORE_DLY;
          end
          4'b0001: begin        // seek
            track <= data_byte;
            delay <= RESTORE_DLY;
          end
          4'b001?: begin        // step, last direction
            delay <= STEP_DLY;
            if (cmd_byte[4])    // update flag
              track <= step_dir ? track + 1'b1 : track - 1'b1;
          end
          4'b010?: begin        // step-in
            delay    <= STEP_DLY;
            step_dir <= 1'b1;
            if (cmd_byte[4])
              track <= track + 1'b1;
          end
          4'b011?: begin        // step-out
            delay    <= STEP_DLY;
            step_dir <= 1'b0;
            if (cmd_byte[4])
              track <= track - 1'b1;
          end
          4'b100?:              // read sector
            state <= st_io_wait;
          4'b101?:              // write sector
            if (!wr_prot) state <= st_io_wait;
          4'b1100,              // read address
          4'b1110:              // read track
            state <= st_io_wait;
          4'b1111:              // write track
            if (!wr_prot) state <= st_io_wait;
          4'b1101: begin        // force interrupt
            if (cmd_byte[3:0] == 4'b0000)
              state <= st_idle; // abort silently
            else
              state <= st_irq;
          end
        endcase
      end
    end
  end

  // irq, set wins over acknowledge
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start)
      irq <= 1'b0;
    else if (state == st_irq)
      irq <= 1'b1;
    else if (irq_ack)
      irq <= 1'b0;
  end

  // motor kick for type I and type II
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start)
      spin_trigger <= 1'b0;
    else
      spin_trigger <= cmd_valid && (is_type_1 || is_type_2);
  end

  // io wait is only entered by a command
  a_io_entry: assert property (@(posedge clk) disable iff (motor_start)
    $rose(io_wait) |-> $past(cmd_valid));

  // finished handshake gives irq two edges on
  a_io_irq: assert property (@(posedge clk) disable iff (motor_start)
    io_wait && io_ready && !cmd_valid |=> ##1 irq);

endmodule

/* fdc_drive_timer.sv */
// floppy drive timing model
// motor run-on counter with spin-up window and a rotating index pulse
`include "fdc_settings.svh"

module fdc_drive_timer (
  input  logic clk,
  input  logic motor_start,
  input  logic spin_trigger,   // a command wants the motor
  output logic motor_on,
  output logic spin_up_done,
  output logic index_pulse
);
  import fdc_pkg::*;

  localparam fdc_count_t RUN_CNT   = fdc_count_t'(`FDC_MOTOR_RUN);
  localparam fdc_count_t START_CNT = fdc_count_t'(`FDC_MOTOR_START);
  localparam fdc_count_t IDX_LAST  = fdc_count_t'(`FDC_INDEX_PERIOD - 1);
  localparam fdc_count_t IDX_WIDTH = fdc_count_t'(`FDC_INDEX_WIDTH);

  fdc_count_t motor_cnt;   // run-on left
  fdc_count_t index_cnt;   // position in the rotation

  assign motor_on     = (motor_cnt != '0);
  // above RUN_CNT the motor is still coming up to speed
  assign spin_up_done = motor_on && (motor_cnt <= RUN_CNT);
  assign index_pulse  = motor_on && (index_cnt < IDX_WIDTH);

  // motor run-on
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start)
      motor_cnt <= '0;
    else if (spin_trigger)
      motor_cnt <= motor_on ? RUN_CNT : START_CNT;  // no spin-up if turning
    else if (motor_cnt != '0)
      motor_cnt <= motor_cnt - 1'b1;
  end

  // rotation position, parked while the motor is off
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start)
      index_cnt <= '0;
    else if (!motor_on)
      index_cnt <= '0;
    else if (index_cnt == IDX_LAST)
      index_cnt <= '0;         // next rotation
    else
      index_cnt <= index_cnt + 1'b1;
  end

  // any trigger leaves the motor running
  a_motor_kick: assert property (@(posedge clk) disable iff (motor_start)
    spin_trigger |=> motor_on);

endmodule

/* fdc_pkg.sv */
// floppy controller shared types
// register bytes, bus address, status view selector, counters
// and the busy state encoding of the execute stage
`include "fdc_settings.svh"

package fdc_pkg;

  // register, command and status value
  typedef logic [7:0] reg_byte_t;

  // cpu register address
  // 0 status/command, 1 track, 2 sector, 3 data
  typedef logic [1:0] reg_addr_t;

  // io controller view selector
  typedef logic [2:0] status_sel_t;

  // delay and drive timing counters
  typedef logic [`FDC_COUNT_W-1:0] fdc_count_t;

  // busy state machine
  typedef enum logic [1:0] {
    st_idle     = 2'd0,  // nothing running
    st_irq      = 2'd1,  // end of busy phase, raises irq
    st_int_wait = 2'd2,  // internal wait, e.g. step settle
    st_io_wait  = 2'd3   // waiting on the io controller
  } busy_state_t;

endpackage

/* fdc_settings.svh */
// floppy controller timing and width constants
// cycle counts are scaled down from the real drive so runs stay short
`ifndef FDC_SETTINGS_SVH
`define FDC_SETTINGS_SVH

// width of the delay, motor and index counters
`define FDC_COUNT_W 24

// restore and seek settle time, real part waits about 25 ms
`define FDC_RESTORE_DELAY 200
// step, step-in and step-out settle time
`define FDC_STEP_DELAY 20

// motor run-on after a command when already spinning
`define FDC_MOTOR_RUN 400
// run-on from standstill, the extra part is spin-up
`define FDC_MOTOR_START 600

// one disk rotation
`define FDC_INDEX_PERIOD 64
// index hole length at the start of a rotation
`define FDC_INDEX_WIDTH 4

`endif

/* fdc_top.sv */
// floppy disk controller, WD1772 style register block
// bus register stage, command execution stage and drive timer
// cpu on one side, io controller and drive pins on the other

module fdc_top (
  input  logic                 clk,
  input  logic                 motor_start,
  // cpu
  input  logic                 cpu_sel,
  input  logic                 cpu_rw,
  input  fdc_pkg::reg_addr_t   cpu_addr,
  input  fdc_pkg::reg_byte_t   cpu_din,
  output fdc_pkg::reg_byte_t   cpu_dout,
  output logic                 irq,
  // io controller
  output logic                 io_valid,
  input  logic                 io_ready,
  input  fdc_pkg::status_sel_t status_sel,
  output fdc_pkg::reg_byte_t   status_byte,
  // drive pins
  input  logic [1:0]           drv_sel,
  input  logic                 drv_side,
  input  logic                 wr_prot
);
  import fdc_pkg::*;

  // bus stage to execute stage
  logic      cmd_valid;
  reg_byte_t cmd_byte;
  reg_byte_t wr_byte;
  logic      track_wr;
  reg_byte_t data_byte;
  logic      irq_ack;
  // execute stage back
  reg_byte_t track;
  logic      busy;
  logic      io_wait;
  logic      spin_trigger;
  // drive timer back
  logic      motor_on;
  logic      spin_up_done;
  logic      index_pulse;

  assign io_valid = io_wait;  // transfer request to io controller

  fdc_bus_regs fdc_bus_regs_i (
    .clk, .motor_start, .cpu_sel, .cpu_rw, .cpu_addr, .cpu_din, .cpu_dout,
    .status_sel, .status_byte, .drv_sel, .drv_side, .wr_prot,
    .track, .busy, .io_wait, .motor_on, .spin_up_done, .index_pulse,
    .cmd_valid, .cmd_byte, .wr_byte, .track_wr, .data_byte, .irq_ack
  );

  fdc_cmd_exec fdc_cmd_exec_i (
    .clk, .motor_start, .cmd_valid, .cmd_byte, .wr_byte, .track_wr,
    .data_byte, .irq_ack, .wr_prot, .io_ready,
    .track, .busy, .io_wait, .irq, .spin_trigger
  );

  fdc_drive_timer fdc_drive_timer_i (
    .clk, .motor_start, .spin_trigger, .motor_on, .spin_up_done, .index_pulse
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the floppy controller testbench with verilator and run it
# the log decides pass or fail

verilator --binary --timing --assert --top-module tb_fdc -f vlog.f -o sim_fdc \
  || { echo "build failed"; exit 1; }
./obj_dir/sim_fdc > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

/* tb_fdc.sv */
// testbench for the floppy controller register block
// cpu register access, type I to IV commands, io handshake and motor timing
`include "fdc_settings.svh"

module tb_fdc;
  timeunit 1ns;
  timeprecision 100ps;
  import fdc_pkg::*;

  // forty type I commands of at most ~215 cycles, 610 cycles of motor test,
  // a few short io commands, then about double as headroom
  localparam int CYCLE_LIMIT = 20000;
  localparam int SPIN_UP     = `FDC_MOTOR_START - `FDC_MOTOR_RUN;

  logic        clk;
  logic        motor_start;
  logic        cpu_sel;
  logic        cpu_rw;
  reg_addr_t   cpu_addr;
  reg_byte_t   cpu_din;
  reg_byte_t   cpu_dout;
  logic        irq;
  logic        io_valid;
  logic        io_ready;
  status_sel_t status_sel;
  reg_byte_t   status_byte;
  logic [1:0]  drv_sel;
  logic        drv_side;
  logic        wr_prot;

  logic [31:0] lfsr;          // random source
  int          cycles;
  reg_byte_t   model_track;   // expected track register
  reg_byte_t   model_data;    // expected data register
  logic        model_dir;     // last step direction (1 = in)

  fdc_top fdc_top_i (.*);

  always #10 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run did not end within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // reference model returning {new dir, io wait follows, new track}
  function automatic logic [9:0] expect_track(input reg_byte_t cmd, input reg_byte_t old,
      input reg_byte_t data, input logic dir, input logic wp);
    reg_byte_t trk;
    logic      io;
    logic      nd;
    trk = old;
    io  = 1'b0;
    nd  = dir;
    if (!cmd[7]) begin
      case (cmd[6:5])
        2'b00:   trk = cmd[4] ? data : 8'h00;  // seek or restore
        2'b01:   ;                             // plain step keeps direction
        2'b10:   nd = 1'b1;                    // step-in
        default: nd = 1'b0;                    // step-out
      endcase
      if (cmd[6:5] != 2'b00 && cmd[4])
        trk = nd ? old + 8'd1 : old - 8'd1;   // update flag set
    end else begin
      case (cmd[7:4])
        4'hd:             io = 1'b0;  // force interrupt
        4'ha, 4'hb, 4'hf: io = !wp;   // writes blocked by protect
        default:          io = 1'b1;  // reads always transfer
      endcase
    end
    return {nd, io, trk};
  endfunction

  task automatic check_byte(input string name, input reg_byte_t exp, input reg_byte_t act);
    if (act !== exp) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic cpu_write(input reg_addr_t addr, input reg_byte_t val);
    @(posedge clk);
    cpu_sel  <= 1'b1;
    cpu_rw   <= 1'b0;
    cpu_addr <= addr;
    cpu_din  <= val;
    @(posedge clk);  // write sampled here
    cpu_sel <= 1'b0;
  endtask

  task automatic cpu_read(input reg_addr_t addr, output reg_byte_t val);
    @(posedge clk);
    cpu_sel  <= 1'b1;
    cpu_rw   <= 1'b1;
    cpu_addr <= addr;
    @(negedge clk);
    val = cpu_dout;   // combinational output settled mid cycle
    @(posedge clk);
    cpu_sel <= 1'b0;
  endtask

  task automatic check_view(input status_sel_t sel, input reg_byte_t exp, input string name);
    @(posedge clk);
    status_sel <= sel;
    @(negedge clk);
    check_byte(name, exp, status_byte);
  endtask

  // write a command and read busy in the cycle right after the state change
  task automatic start_cmd(input reg_byte_t cmd, input logic exp_busy, input string name);
    reg_byte_t st;
    cpu_write(2'd0, cmd);
    cpu_read(2'd0, st);
    check_bit({name, " busy"}, exp_busy, st[0]);
  endtask

  task automatic wait_irq(input int delay, input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (irq !== 1'b1) begin
      if (n >= delay + 8) begin
        $display("irq did not rise within %0d cycles in %s", delay + 8, name);
        abort_run();
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic clear_irq(input string name);
    reg_byte_t st;
    cpu_read(2'd0, st);  // status read acks
    @(posedge clk);
    @(negedge clk);
    check_bit({name, " irq cleared"}, 1'b0, irq);
  endtask

  // io controller answers after delay cycles of back-pressure
  task automatic io_answer(input int delay, input string name);
    repeat (delay) @(posedge clk);
    @(negedge clk);
    check_bit({name, " io_valid held"}, 1'b1, io_valid);
    @(posedge clk);
    io_ready <= 1'b1;
    @(posedge clk);   // handshake edge
    io_ready <= 1'b0;
    @(negedge clk);
    check_bit({name, " io_valid drop"}, 1'b0, io_valid);
  endtask

  // type II or III command through to irq
  task automatic run_io(input reg_byte_t cmd, input int delay, input string name);
    logic [9:0] ref_out;
    start_cmd(cmd, 1'b1, name);
    ref_out = expect_track(cmd, model_track, model_data, model_dir, wr_prot);
    @(negedge clk);
    check_bit({name, " io_valid"}, ref_out[8], io_valid);
    check_view(3'd4, {4'h0, drv_sel, drv_side, ref_out[8]}, {name, " io view"});
    check_view(3'd0, cmd, {name, " cmd view"});
    if (ref_out[8])
      io_answer(delay, name);
    wait_irq(8, name);
    clear_irq(name);
  endtask

  initial begin
    int          k;
    int          dly;
    logic [31:0] r;
    logic [9:0]  ref_out;
    reg_byte_t   cmd;
    reg_byte_t   rd;
    clk         = 1'b0;
    motor_start = 1'b1;
    cpu_sel     = 1'b0;
    cpu_rw      = 1'b0;
    cpu_addr    = '0;
    cpu_din     = '0;
    io_ready    = 1'b0;
    status_sel  = '0;
    drv_sel     = '0;
    drv_side    = 1'b0;
    wr_prot     = 1'b0;
    lfsr        = 32'haa382620;
    cycles      = 0;
    model_track = 8'h00;
    model_data  = 8'h00;
    model_dir   = 1'b0;
    repeat (4) @(posedge clk);
    motor_start <= 1'b0;

    // register write and read back on the cpu side and in the io view
    for (k = 0; k < 8; k++) begin
      r = rand_bits(26);
      cpu_write(2'd1, r[7:0]);
      cpu_write(2'd2, r[15:8]);
      cpu_write(2'd3, r[23:16]);
      model_track = r[7:0];
      model_data  = r[23:16];
      cpu_read(2'd1, rd);
      check_byte("reg track", r[7:0], rd);
      cpu_read(2'd2, rd);
      check_byte("reg sector", r[15:8], rd);
      cpu_read(2'd3, rd);
      check_byte("reg data", r[23:16], rd);
      check_view(3'd1, r[7:0], "view track");
      check_view(3'd2, r[15:8], "view sector");
      check_view(3'd3, r[23:16], "view data");
      @(posedge clk);
      cpu_rw   <= 1'b1;
      cpu_addr <= r[25:24];
      @(negedge clk);
      check_byte("deselected read", 8'h00, cpu_dout);
    end

    // motor from standstill with restore as first command
    cpu_write(2'd0, 8'h00);
    ref_out     = expect_track(8'h00, model_track, model_data, model_dir, wr_prot);
    model_track = ref_out[7:0];
    model_dir   = ref_out[9];
    repeat (3) @(posedge clk);
    cpu_read(2'd0, rd);
    check_bit("motor on", 1'b1, rd[7]);
    check_bit("spin-up at start", 1'b0, rd[5]);
    repeat (SPIN_UP - 8) @(posedge clk);
    cpu_read(2'd0, rd);                        // 4 cycles before spin-up ends
    check_bit("spin-up early", 1'b0, rd[5]);
    repeat (6) @(posedge clk);
    cpu_read(2'd0, rd);                        // 4 cycles after
    check_bit("spin-up done", 1'b1, rd[5]);
    repeat (`FDC_MOTOR_RUN - 10) @(posedge clk);
    cpu_read(2'd0, rd);                        // 4 cycles before the motor stops
    check_bit("motor run-on", 1'b1, rd[7]);
    repeat (6) @(posedge clk);
    cpu_read(2'd0, rd);                        // 4 cycles after
    check_bit("motor off", 1'b0, rd[7]);
    cpu_read(2'd1, rd);
    check_byte("restore track", model_track, rd);

    // random type I commands
    for (k = 0; k < 40; k++) begin
      r          = rand_bits(15);
      model_data = r[7:0];
      cpu_write(2'd3, model_data);
      cmd     = {1'b0, r[14:8]};
      ref_out = expect_track(cmd, model_track, model_data, model_dir, wr_prot);
      dly     = (cmd[6:5] == 2'b00) ? `FDC_RESTORE_DELAY : `FDC_STEP_DELAY;
      start_cmd(cmd, 1'b1, "type1");
      wait_irq(dly, "type1");
      cpu_read(2'd1, rd);
      check_byte("type1 track", ref_out[7:0], rd);
      model_track = ref_out[7:0];
      model_dir   = ref_out[9];
      clear_irq("type1");
    end

    // read sector, read address, read track with random io delay
    for (k = 0; k < 6; k++) begin
      r = rand_bits(11);
      @(posedge clk);
      drv_sel  <= r[9:8];
      drv_side <= r[10];
      case (k % 3)
        0:       cmd = {3'b100, r[4:0]};
        1:       cmd = {4'b1100, r[3:0]};
        default: cmd = {4'b1110, r[3:0]};
      endcase
      run_io(cmd, int'(r[7:4]), "read io");
    end

    // protected then open write sector and write track
    @(posedge clk);
    wr_prot <= 1'b1;
    r = rand_bits(13);
    run_io({3'b101, r[4:0]}, 0, "write sector protected");
    run_io({4'b1111, r[8:5]}, 0, "write track protected");
    @(posedge clk);
    wr_prot <= 1'b0;
    run_io({3'b101, r[4:0]}, int'(r[12:9]), "write sector open");
    r = rand_bits(8);
    run_io({4'b1111, r[3:0]}, int'(r[7:4]), "write track open");

    // force interrupt aborting a pending read silently and then with irq
    start_cmd(8'h80, 1'b1, "force pending");
    @(negedge clk);
    check_bit("force pending io_valid", 1'b1, io_valid);
    start_cmd(8'hd0, 1'b0, "force d0");
    @(negedge clk);
    check_bit("force d0 io_valid", 1'b0, io_valid);
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_bit("force d0 irq", 1'b0, irq);
    start_cmd(8'hd8, 1'b1, "force d8");
    wait_irq(0, "force d8");
    clear_irq("force d8");

    $display("all tests passed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
fdc_pkg.sv
fdc_bus_regs.sv
fdc_cmd_exec.sv
fdc_drive_timer.sv
fdc_top.sv
tb_fdc.sv
